/* compile.f */
battleDisplayPkg.sv
fleetRegs.sv
vgaTiming.sv
shipRenderer.sv
pixelCompositor.sv
battleDisplayTop.sv
battleDisplayTb.sv

/* run.sh */
#!/bin/sh
# Build the display testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module battleDisplayTb -f compile.f \
	-o battleDisplaySim
./obj_dir/battleDisplaySim > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0

/* battleDisplayTb.sv */
`timescale 1ns/1ps

module battleDisplayTb
	import battleDisplayPkg::*;
();

	typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_PROBE} testKind_e;

	typedef struct
	{
		string name;
		testKind_e kind;
		logic [4:0] addr; // Bus address
		logic [9:0] col; // Probe pixel
		logic [9:0] row;
		logic [31:0] data;
		logic [3:0] strb;
		logic [31:0] expVal; // Read data or rgb
		logic [1:0] expResp;
	} testEntry_t;

	localparam int lineCycles = 800;
	localparam int frameLines = 525;
	localparam int vsyncLine = 490;
	localparam int activeCols = 640; // Visible window
	localparam int activeRows = 480;
	// Output vsync and rgb both lag the counters by one cycle, so the lags cancel
	localparam int vsyncToFrame = (frameLines - vsyncLine) * lineCycles;
	localparam int busLimit = 20; // Cycles to wait for a handshake
	localparam logic [31:0] black = 32'h0; // rgb as {r, g, b}
	localparam logic [31:0] green = 32'h2;
	localparam logic [31:0] red = 32'h4;
	localparam logic [31:0] yellow = 32'h6;
	localparam logic [31:0] violet = 32'h5;
	localparam logic [31:0] cyan = 32'h3;

	logic clk;
	logic rstN;
	axiWrReq_t wrReq;
	axiWrRsp_t wrRsp;
	axiRdReq_t rdReq;
	axiRdRsp_t rdRsp;
	rgb_t rgb;
	logic hsync;
	logic vsync;
	logic videoActive;

	testEntry_t tests [$];
	int probeCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	logic [31:0] lfsr = 32'h191a_11d3;

	battleDisplayTop uut (.clk(clk), .rstN(rstN), .wrReq(wrReq), .wrRsp(wrRsp), .rdReq(rdReq),
		.rdRsp(rdRsp), .rgb(rgb), .hsync(hsync), .vsync(vsync), .videoActive(videoActive));

	always #2 clk = ~clk;

	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois taps 32,22,2,1
	endfunction

	function automatic int randomBits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]); // One step per bit
			lfsr = nextLfsr(lfsr);
		end
		return v;
	endfunction

	// Left border of column x and lower border of row y
	function automatic logic [9:0] cellLeft(input int x);
		return 10'(16 + (x - 1) * 62);
	endfunction

	function automatic logic [9:0] cellDown(input int y);
		return 10'(16 + (y - 1) * 57);
	endfunction

	task automatic addBusTest(input string name, input testKind_e kind, input logic [4:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input logic [31:0] expVal,
		input logic [1:0] expResp);
		testEntry_t e;
		e = '{name: name, kind: kind, addr: addr, col: 10'd0, row: 10'd0, data: data,
			strb: strb, expVal: expVal, expResp: expResp};
		tests.push_back(e);
	endtask

	task automatic addProbeTest(input string name, input logic [9:0] col, input logic [9:0] row,
		input logic [31:0] expVal);
		testEntry_t e;
		e = '{name: name, kind: OP_PROBE, addr: 5'd0, col: col, row: row, data: 32'd0,
			strb: 4'd0, expVal: expVal, expResp: 2'd0};
		tests.push_back(e);
		probeCount++;
	endtask

	task automatic buildTable();
		for (int a = 0; a < 5; a++)
		begin
			addBusTest($sformatf("reset read %0d", a), OP_READ, 5'(a * 4), 0, 0, 0, 2'd0);
		end
		addBusTest("full write", OP_WRITE, 5'h04, 32'h1234_5678, 4'hf, 0, 2'd0);
		addBusTest("full read", OP_READ, 5'h04, 0, 0, 32'h1234_5678, 2'd0);
		addBusTest("partial write", OP_WRITE, 5'h04, 32'haabb_ccdd, 4'b0101, 0, 2'd0);
		addBusTest("partial read", OP_READ, 5'h04, 0, 0, 32'h12bb_56dd, 2'd0);
		addBusTest("bad write 0x14", OP_WRITE, 5'h14, 32'hffff_ffff, 4'hf, 0, 2'd2);
		addBusTest("bad write 0x1c", OP_WRITE, 5'h1c, 32'hffff_ffff, 4'hf, 0, 2'd2);
		addBusTest("bad read 0x14", OP_READ, 5'h14, 0, 0, 0, 2'd2);
		addBusTest("cruiser kept", OP_READ, 5'h04, 0, 0, 32'h12bb_56dd, 2'd0);
		addBusTest("submarine write", OP_WRITE, 5'h00, 32'h0000_0032, 4'hf, 0, 2'd0); // (2,3)
		addBusTest("seaplane write", OP_WRITE, 5'h08, 32'h7708_2111, 4'hf, 0, 2'd0);
		addBusTest("battleship write", OP_WRITE, 5'h0c, 32'h0097_2988, 4'hf, 0,
			2'd0); // (8,8) then (9,2) and (7,9) hidden
		addBusTest("carrier write", OP_WRITE, 5'h10, 32'h3534_3332, 4'hf, 0, 2'd0); // Row 3
		addBusTest("carrier read", OP_READ, 5'h10, 0, 0, 32'h3534_3332, 2'd0);
		addProbeTest("overlap green", cellLeft(2) + 1, cellDown(3) + 1, green);
		addProbeTest("carrier cyan", cellLeft(4) + 1, cellDown(3) + 1, cyan);
		addProbeTest("carrier corner", cellLeft(5) + 53, cellDown(3) + 48, cyan);
		addProbeTest("border column", cellLeft(4), cellDown(3) + 1, black);
		addProbeTest("border row", cellLeft(4) + 1, cellDown(3), black);
		addProbeTest("right of cell", cellLeft(4) + 54, cellDown(3) + 1, black);
		addProbeTest("cruiser red", cellLeft(6) + 1, cellDown(5) + 1, red); // Slot 1 only
		addProbeTest("seaplane yellow", cellLeft(1) + 1, cellDown(1) + 1, yellow);
		addProbeTest("seaplane slot 3", cellLeft(7) + 1, cellDown(7) + 1, black);
		addProbeTest("battleship violet", cellLeft(8) + 1, cellDown(8) + 1, violet);
		addProbeTest("column 9 hidden", cellLeft(9) + 1, cellDown(2) + 1, black); // Still on screen
		addProbeTest("row 9 hidden", cellLeft(7) + 1, cellDown(9) + 1, black);
		addProbeTest("hblank", 10'd700, 10'd100, black);
		addProbeTest("vblank", cellLeft(2) + 1, 10'd485, black); // Last row probed
	endtask

	task automatic busWrite(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		int waited;
		waited = 0;
		@(posedge clk);
		wrReq.awaddr <= addr;
		wrReq.wdata <= data;
		wrReq.wstrb <= strb;
		wrReq.awvalid <= 1'b1;
		wrReq.wvalid <= 1'b1;
		#1;
		while (!(wrRsp.awready && wrRsp.wready) && waited < busLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!(wrRsp.awready && wrRsp.wready))
		begin
			errorCount++;
			$display("Write to address %h was not accepted on AW and W together", addr);
		end
		@(posedge clk); // AW and W taken
		wrReq.awvalid <= 1'b0;
		wrReq.wvalid <= 1'b0;
		repeat (randomBits(3)) @(posedge clk); // Random bready stall
		wrReq.bready <= 1'b1;
		#1;
		waited = 0;
		while (!wrRsp.bvalid && waited < busLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!wrRsp.bvalid)
		begin
			errorCount++;
			$display("Write to address %h got no response", addr);
		end
		resp = wrRsp.bresp;
		@(posedge clk); // B taken
		wrReq.bready <= 1'b0;
	endtask

	task automatic busRead(input logic [4:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int waited;
		waited = 0;
		@(posedge clk);
		rdReq.araddr <= addr;
		rdReq.arvalid <= 1'b1;
		#1;
		while (!rdRsp.arready && waited < busLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		@(posedge clk); // AR taken
		rdReq.arvalid <= 1'b0;
		repeat (randomBits(3)) @(posedge clk); // Random rready stall
		rdReq.rready <= 1'b1;
		#1;
		waited = 0;
		while (!rdRsp.rvalid && waited < busLimit)
		begin
			@(posedge clk);
			#1;
			waited++;
		end
		if (!rdRsp.rvalid)
		begin
			errorCount++;
			$display("Read from address %h got no response", addr);
		end
		data = rdRsp.rdata;
		resp = rdRsp.rresp;
		@(posedge clk); // R taken
		rdReq.rready <= 1'b0;
	endtask

	task automatic probePixel(input logic [9:0] col, input logic [9:0] row, output rgb_t value,
		output logic active);
		@(negedge vsync); // Frame reference
		repeat (vsyncToFrame + int'(row) * lineCycles + int'(col)) @(posedge clk);
		#1;
		value = rgb;
		active = videoActive;
	endtask

	// One frame from vsync fall to vsync fall
	task automatic checkSyncFrame();
		int pulses;
		int lowRun;
		int guard;
		logic hPrev;
		logic vPrev;
		logic closed;
		pulses = 0;
		lowRun = 0;
		guard = 0;
		closed = 1'b0;
		@(negedge vsync);
		#1;
		hPrev = hsync;
		vPrev = vsync;
		while (!closed && guard < frameLines * lineCycles + busLimit)
		begin
			@(posedge clk);
			#1;
			guard++;
			if (!hsync)
			begin
				lowRun++;
			end
			else if (!hPrev)
			begin
				pulses++;
				checkCount++;
				if (lowRun != 96)
				begin
					errorCount++;
					$display("FAILED hsync width: expected 96, actual %0d", lowRun);
				end
				lowRun = 0;
			end
			closed = vPrev && !vsync; // Next frame starts
			hPrev = hsync;
			vPrev = vsync;
		end
		checkCount++;
		if (!closed)
		begin
			errorCount++;
			$display("Second vsync falling edge did not arrive within a frame");
		end
		else if (pulses != frameLines)
		begin
			errorCount++;
			$display("FAILED hsync count: expected %0d, actual %0d", frameLines, pulses);
		end
	endtask

	initial
	begin
		wait (probeCount > 0);
		#((longint'(probeCount) + 2) * 420000 * 4 + 10000); // Frame time per probe plus slack
		$display("Watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		logic [31:0] data;
		logic [1:0] resp;
		rgb_t color;
		logic active;
		logic expActive;
		clk = 1'b0;
		rstN = 1'b0;
		wrReq = '0;
		rdReq = '0;
		buildTable();
		repeat (2) @(posedge clk);
		#1;
		checkCount++;
		if ({rgb, videoActive, hsync, vsync, wrRsp.bvalid, rdRsp.rvalid, rdRsp.arready}
			!== 9'b000_0110_01)
		begin
			errorCount++;
			$display("FAILED reset state: expected 00000110 01, actual %b %b%b%b%b%b%b", rgb,
				videoActive, hsync, vsync, wrRsp.bvalid, rdRsp.rvalid, rdRsp.arready);
		end
		@(posedge clk);
		rstN <= 1'b1; // Released after 3 rising edges
		foreach (tests[i])
		begin
			case (tests[i].kind)
				OP_WRITE:
				begin
					busWrite(tests[i].addr, tests[i].data, tests[i].strb, resp);
				end
				OP_READ:
				begin
					busRead(tests[i].addr, data, resp);
					checkCount++;
					if (data !== tests[i].expVal)
					begin
						errorCount++;
						$display("FAILED %s: expected %h, actual %h", tests[i].name,
							tests[i].expVal, data);
					end
				end
				default:
				begin
					probePixel(tests[i].col, tests[i].row, color, active);
					checkCount++;
					if (32'(color) !== tests[i].expVal)
					begin
						errorCount++;
						$display("FAILED %s: expected %h, actual %h", tests[i].name,
							tests[i].expVal, color);
					end
					expActive = (int'(tests[i].col) < activeCols)
						&& (int'(tests[i].row) < activeRows); // Inside the visible window
					checkCount++;
					if (active !== expActive)
					begin
						errorCount++;
						$display("FAILED %s videoActive: expected %b, actual %b", tests[i].name,
							expActive, active);
					end
				end
			endcase
			if (tests[i].kind != OP_PROBE)
			begin
				checkCount++;
				if (resp !== tests[i].expResp)
				begin
					errorCount++;
					$display("FAILED %s response: expected %h, actual %h", tests[i].name,
						tests[i].expResp, resp);
				end
			end
		end
		checkSyncFrame();
		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* battleDisplayTop.sv */
`timescale 1ns/1ps

module battleDisplayTop
	import battleDisplayPkg::*;
#(
	parameter int shipCount = 5,
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33
)
(
	input logic clk,
	input logic rstN,
	input axiWrReq_t wrReq,
	output axiWrRsp_t wrRsp,
	input axiRdReq_t rdReq,
	output axiRdRsp_t rdRsp,
	output rgb_t rgb,
	output logic hsync,
	output logic vsync,
	output logic videoActive
);

	shipCells_t [shipCount-1:0] ships; // One register per ship kind
	pixelPos_t pixel;
	logic hsyncRaw;
	logic vsyncRaw;
	logic [shipCount-1:0] hits;

	fleetRegs #(.shipCount(shipCount)) uRegs (.clk(clk), .rstN(rstN), .wrReq(wrReq),
		.wrRsp(wrRsp), .rdReq(rdReq), .rdRsp(rdRsp), .ships(ships));

	vgaTiming #(.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)) uTiming (.clk(clk),
		.rstN(rstN), .pixel(pixel), .hsync(hsyncRaw), .vsync(vsyncRaw));

	// Ship length sets how many slots each renderer draws
	shipRenderer #(.cellCount(1)) uSubmarine (.clk(clk), .rstN(rstN),
		.cells(ships[SUBMARINE]), .pixel(pixel), .hit(hits[SUBMARINE]));
	shipRenderer #(.cellCount(2)) uCruiser (.clk(clk), .rstN(rstN),
		.cells(ships[CRUISER]), .pixel(pixel), .hit(hits[CRUISER]));
	shipRenderer #(.cellCount(3)) uSeaplane (.clk(clk), .rstN(rstN),
		.cells(ships[SEAPLANE]), .pixel(pixel), .hit(hits[SEAPLANE]));
	shipRenderer #(.cellCount(4)) uBattleship (.clk(clk), .rstN(rstN),
		.cells(ships[BATTLESHIP]), .pixel(pixel), .hit(hits[BATTLESHIP]));
	shipRenderer #(.cellCount(4)) uCarrier (.clk(clk), .rstN(rstN),
		.cells(ships[CARRIER]), .pixel(pixel), .hit(hits[CARRIER]));

	pixelCompositor #(.shipCount(shipCount)) uCompositor (.clk(clk), .rstN(rstN),
		.hits(hits), .pixel(pixel), .hsyncIn(hsyncRaw), .vsyncIn(vsyncRaw), .rgb(rgb),
		.hsync(hsync), .vsync(vsync), .videoActive(videoActive));

endmodule

/* pixelCompositor.sv */
`timescale 1ns/1ps

module pixelCompositor
	import battleDisplayPkg::*;
#(
	parameter int shipCount = 5
)
(
	input logic clk,
	input logic rstN,
	input logic [shipCount-1:0] hits,
	input pixelPos_t pixel,
	input logic hsyncIn,
	input logic vsyncIn,
	output rgb_t rgb,
	output logic hsync,
	output logic vsync,
	output logic videoActive
);

	shipKind_e winner; // Lowest index ship with a hit
	logic anyHit;
	rgb_t color;

	always_comb
	begin
		winner = SUBMARINE;
		anyHit = 1'b0;
		for (int i = shipCount - 1; i >= 0; i--)
		begin
			if (hits[i])
			begin
				winner = shipKind_e'(i); // Later match is lower index and wins
				anyHit = 1'b1;
			end
		end
		color = (anyHit && pixel.active) ? shipColor[winner] : '0; // Black background and blanking
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rgb <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
			videoActive <= 1'b0;
		end
		else
		begin
			rgb <= color;
			hsync <= hsyncIn; // Delayed to match rgb
			vsync <= vsyncIn;
			videoActive <= pixel.active;
		end
	end

endmodule

/* shipRenderer.sv */
`timescale 1ns/1ps

module shipRenderer
	import battleDisplayPkg::*;
#(
	parameter int cellCount = 4
)
(
	input logic clk,
	input logic rstN,
	input shipCells_t cells,
	input pixelPos_t pixel,
	output logic hit
);

	logic [9:0] borderLeft [cellCount]; // Left pixel border per slot
	logic [9:0] borderDown [cellCount]; // Lower pixel border per slot
	logic [cellCount-1:0] drawn; // Slot holds a real map cell
	logic [cellCount-1:0] slotHit;

	for (genvar s = 0; s < cellCount; s++)
	begin : gSlot
		cellPos_t slotCell;
		logic slotValid;

		assign slotCell = cells[s];
		assign slotValid = (slotCell.x >= 4'd1) && (slotCell.x <= 4'd8)
			&& (slotCell.y >= 4'd1) && (slotCell.y <= 4'd8); // 0 and 9..15 hide the slot

		always_ff @(posedge clk or negedge rstN)
		begin
			if (!rstN)
			begin
				drawn[s] <= 1'b0;
			end
			else
			begin
				drawn[s] <= slotValid;
			end
		end

		// Border of cell n is origin + (n-1) steps
		always_ff @(posedge clk)
		begin
			borderLeft[s] <= gridOrigin + (10'(slotCell.x) - 10'd1) * cellStepX;
			borderDown[s] <= gridOrigin + (10'(slotCell.y) - 10'd1) * cellStepY;
		end

		// Strictly inside all four borders
		assign slotHit[s] = drawn[s]
			&& (pixel.col > borderLeft[s]) && (pixel.col < borderLeft[s] + cellWidth)
			&& (pixel.row > borderDown[s]) && (pixel.row < borderDown[s] + cellHeight);
	end

	assign hit = |slotHit; // Any drawn cell of this ship

endmodule

/* vgaTiming.sv */
`timescale 1ns/1ps

module vgaTiming
	import battleDisplayPkg::*;
#(
	parameter int hActive = 640,
	parameter int hFront = 16,
	parameter int hSync = 96,
	parameter int hBack = 48,
	parameter int vActive = 480,
	parameter int vFront = 10,
	parameter int vSync = 2,
	parameter int vBack = 33
)
(
	input logic clk,
	input logic rstN,
	output pixelPos_t pixel,
	output logic hsync,
	output logic vsync
);

	localparam logic [9:0] hLast = 10'(hActive + hFront + hSync + hBack - 1); // 799
	localparam logic [9:0] vLast = 10'(vActive + vFront + vSync + vBack - 1); // 524
	localparam logic [9:0] hSyncStart = 10'(hActive + hFront);
	localparam logic [9:0] hSyncEnd = 10'(hActive + hFront + hSync); // First cycle after pulse
	localparam logic [9:0] vSyncStart = 10'(vActive + vFront);
	localparam logic [9:0] vSyncEnd = 10'(vActive + vFront + vSync);
	localparam logic [9:0] hVisible = 10'(hActive);
	localparam logic [9:0] vVisible = 10'(vActive);

	logic [9:0] hCnt;
	logic [9:0] vCnt;
	logic [9:0] hNext;
	logic [9:0] vNext;
	logic activeQ;

	always_comb
	begin
		hNext = hCnt + 10'd1;
		vNext = vCnt;
		if (hCnt == hLast)
		begin
			hNext = '0; // Line wrap steps the row
			vNext = (vCnt == vLast) ? 10'd0 : vCnt + 10'd1;
		end
	end

	// Flags are registered from the next count so they line up with the counters
	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			hCnt <= '0;
			vCnt <= '0;
			activeQ <= 1'b1; // Pixel (0,0) is visible
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			hCnt <= hNext;
			vCnt <= vNext;
			activeQ <= (hNext < hVisible) && (vNext < vVisible);
			hsync <= !((hNext >= hSyncStart) && (hNext < hSyncEnd)); // Active low
			vsync <= !((vNext >= vSyncStart) && (vNext < vSyncEnd));
		end
	end

	always_comb
	begin
		pixel.row = vCnt;
		pixel.col = hCnt;
		pixel.active = activeQ;
	end

endmodule

/* fleetRegs.sv */
`timescale 1ns/1ps

module fleetRegs
	import battleDisplayPkg::*;
#(
	parameter int shipCount = 5
)
(
	input logic clk,
	input logic rstN,
	input axiWrReq_t wrReq,
	output axiWrRsp_t wrRsp,
	input axiRdReq_t rdReq,
	output axiRdRsp_t rdRsp,
	output shipCells_t [shipCount-1:0] ships
);

	busState_e wrState; // Write channel FSM
	busState_e rdState; // Read channel FSM
	logic [1:0] bresp; // Held until bready
	logic [1:0] rresp; // Held until rready
	logic [31:0] rdata;

	logic [2:0] wrIdx;
	logic [2:0] rdIdx;
	logic wrHit; // Write address maps to a ship register
	logic rdHit;
	logic wrFire; // AW and W taken together
	logic rdFire;

	assign wrIdx = wrReq.awaddr[4:2];
	assign rdIdx = rdReq.araddr[4:2];
	assign wrHit = (wrReq.awaddr[1:0] == 2'b00) && (int'(wrIdx) < shipCount); // Word aligned only
	assign rdHit = (rdReq.araddr[1:0] == 2'b00) && (int'(rdIdx) < shipCount);
	assign wrFire = (wrState == IDLE) && wrReq.awvalid && wrReq.wvalid;
	assign rdFire = (rdState == IDLE) && rdReq.arvalid;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			wrState <= IDLE;
			bresp <= respOkay;
			ships <= '0; // Nothing drawn
		end
		else
		begin
			case (wrState)
				IDLE:
				begin
					if (wrFire)
					begin
						wrState <= RESPOND; // bvalid next cycle
						bresp <= wrHit ? respOkay : respSlvErr;
						if (wrHit)
						begin
							for (int b = 0; b < 4; b++)
							begin
								if (wrReq.wstrb[b])
								begin
									ships[wrIdx][b] <= wrReq.wdata[b*8 +: 8]; // One slot per byte
								end
							end
						end
					end
				end
				RESPOND:
				begin
					if (wrReq.bready)
					begin
						wrState <= IDLE;
					end
				end
				default: wrState <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			rdState <= IDLE;
			rresp <= respOkay;
		end
		else
		begin
			case (rdState)
				IDLE:
				begin
					if (rdFire)
					begin
						rdState <= RESPOND;
						rresp <= rdHit ? respOkay : respSlvErr;
					end
				end
				RESPOND:
				begin
					if (rdReq.rready)
					begin
						rdState <= IDLE;
					end
				end
				default: rdState <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdFire)
		begin
			rdata <= rdHit ? ships[rdIdx] : '0; // Bad address reads zero
		end
	end

	always_comb
	begin
		wrRsp.awready = wrFire; // One cycle pulse with wready
		wrRsp.wready = wrFire;
		wrRsp.bresp = bresp;
		wrRsp.bvalid = (wrState == RESPOND);
		rdRsp.arready = (rdState == IDLE);
		rdRsp.rdata = rdata;
		rdRsp.rresp = rresp;
		rdRsp.rvalid = (rdState == RESPOND);
	end

endmodule

/* battleDisplayPkg.sv */
package battleDisplayPkg;

	typedef struct packed
	{
		logic [3:0] y; // Grid row, 1..8 drawn
		logic [3:0] x; // Grid column, 1..8 drawn
	} cellPos_t;

	typedef cellPos_t [3:0] shipCells_t; // Slot 0 in the low byte

	typedef struct packed
	{
		logic [9:0] row;
		logic [9:0] col;
		logic active; // Inside the 640x480 window
	} pixelPos_t;

	typedef struct packed
	{
		logic r;
		logic g;
		logic b;
	} rgb_t;

	typedef struct packed
	{
		logic [4:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
	} axiWrReq_t;

	typedef struct packed
	{
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
	} axiWrRsp_t;

	typedef struct packed
	{
		logic [4:0] araddr;
		logic arvalid;
		logic rready;
	} axiRdReq_t;

	typedef struct packed
	{
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiRdRsp_t;

	typedef enum logic [2:0]
	{
		SUBMARINE = 3'd0,
		CRUISER = 3'd1,
		SEAPLANE = 3'd2,
		BATTLESHIP = 3'd3,
		CARRIER = 3'd4
	} shipKind_e; // Ship index and register index

	typedef enum logic
	{
		IDLE = 1'b0,
		RESPOND = 1'b1
	} busState_e;

	// Screen mapping of the 8x8 map
	localparam logic [9:0] gridOrigin = 10'd16; // Border of cell 1 in both axes
	localparam logic [9:0] cellStepX = 10'd62;
	localparam logic [9:0] cellStepY = 10'd57;
	localparam logic [9:0] cellWidth = 10'd54;
	localparam logic [9:0] cellHeight = 10'd49;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	localparam rgb_t shipColor [5] = '{
		'{r: 1'b0, g: 1'b1, b: 1'b0}, // Submarine green
		'{r: 1'b1, g: 1'b0, b: 1'b0}, // Cruiser red
		'{r: 1'b1, g: 1'b1, b: 1'b0}, // Seaplane yellow
		'{r: 1'b1, g: 1'b0, b: 1'b1}, // Battleship violet
		'{r: 1'b0, g: 1'b1, b: 1'b1}  // Carrier cyan
	};

endpackage
